// ==== g729_params.svh ====
`ifndef G729_PARAMS_SVH
`define G729_PARAMS_SVH

// Scratch memory geometry
`define MEM_DEPTH 2048
`define MEM_ADDR_W 11

// LPC order M and MA predictor order MA_NP
`define LPC_ORDER 10
`define MA_ORDER 4

// Final L_shl amount applied to the L_mult product
`define LSP_SHIFT 3

// 32-bit saturation limits
`define MAX_32 32'sh7fff_ffff
`define MIN_32 32'sh8000_0000

`endif

// ==== lspPkg.sv ====
`default_nettype none

`include "g729_params.svh"

package lspPkg;

	//////////////////////////////////////////////////
	// Fixed-point words
	//////////////////////////////////////////////////
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	// Scratch memory address
	typedef logic [`MEM_ADDR_W-1:0] memAddr;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// Base addresses of the five arrays
	typedef struct packed {
		memAddr lspEle;
		memAddr fg;
		memAddr fgSumInv;
		memAddr freqPrev;
		memAddr lsp;
	} lspBases;

	// One memory request, host or engine
	typedef struct packed {
		memAddr addr;
		word32 wrData;
		logic we;
		logic re;
	} memReq;

	// Extraction engine FSM
	typedef enum logic [3:0] {
		IDLE,
		READ_LSP,
		READ_FREQ,
		READ_FG,
		ACCUM,
		READ_INV,
		MULT,
		SHIFT,
		WRITE,
		FINISH
	} engineState;

endpackage

`default_nettype wire

// ==== scratchMemory.sv ====
`default_nettype none

`include "g729_params.svh"

module scratchMemory import lspPkg::*;
(
	input wire clk,
	input wire memAddr wrAddr,
	input wire word32 wrData,
	input wire we,
	input wire memAddr rdAddr,
	output word32 rdData
);

	// 16-bit values kept sign-extended in 32-bit words
	word32 mem [`MEM_DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

// ==== memArbiter.sv ====
`default_nettype none

module memArbiter import lspPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire memReq hostReq,
	input wire memReq engReq,
	output logic hostGnt,
	output logic hostRdValid,
	output logic engRdValid,
	output memAddr memWrAddr,
	output word32 memWrData,
	output logic memWe,
	output memAddr memRdAddr
);

	logic engSel;
	logic hostSel;
	memReq owner;

	//////////////////////////////////////////////////
	// Owner selection
	//////////////////////////////////////////////////

	// Engine has fixed priority
	assign engSel = engReq.re | engReq.we;

	// Host only gets the gaps
	assign hostSel = !engSel && (hostReq.re || hostReq.we);
	assign hostGnt = hostSel;

	assign owner = engSel ? engReq : hostReq;

	//////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////
	assign memWrAddr = owner.addr;
	assign memRdAddr = owner.addr;
	assign memWrData = owner.wrData;

	// No write when neither side is granted
	assign memWe = owner.we & (engSel | hostSel);

	//////////////////////////////////////////////////
	// Read return tagging
	//////////////////////////////////////////////////

	// Data comes back one cycle after the granted read
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			hostRdValid <= 1'b0;
			engRdValid <= 1'b0;
		end
		else
		begin
			hostRdValid <= hostSel & hostReq.re;
			engRdValid <= engReq.re;
		end
	end

endmodule

`default_nettype wire

// ==== mulSubUnit.sv ====
`default_nettype none

`include "g729_params.svh"

module mulSubUnit import lspPkg::*;
(
	input wire word16 a,
	input wire word16 b,
	input wire word32 acc,
	output word32 multOut,
	output word32 msuOut
);

	word32 rawProd;
	logic [32:0] diff;
	logic subOvf;

	//////////////////////////////////////////////////
	// L_mult
	//////////////////////////////////////////////////

	// Single shared multiplier
	assign rawProd = a * b;

	// Only -32768 * -32768 overflows after doubling
	always_comb
	begin
		if (a == 16'sh8000 && b == 16'sh8000)
		begin
			multOut = `MAX_32;
		end
		else
		begin
			multOut = rawProd <<< 1;
		end
	end

	//////////////////////////////////////////////////
	// L_msu
	//////////////////////////////////////////////////

	// 33-bit difference exposes the overflow
	assign diff = {acc[31], acc} - {multOut[31], multOut};
	assign subOvf = diff[32] ^ diff[31];

	always_comb
	begin
		if (subOvf)
		begin
			// Clamp toward the sign of the true result
			msuOut = diff[32] ? `MIN_32 : `MAX_32;
		end
		else
		begin
			msuOut = diff[31:0];
		end
	end

endmodule

`default_nettype wire

// ==== lShiftSeq.sv ====
`default_nettype none

`include "g729_params.svh"

module lShiftSeq import lspPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire shlReady,
	input wire word32 shlIn,
	output logic shlDone,
	output word32 shlOut
);

	localparam int CNT_W = $clog2(`LSP_SHIFT + 1);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] nextCnt;
	word32 shiftReg;
	word32 src;
	word32 stepped;
	logic ovf;
	logic finish;

	// First shift happens on the load cycle
	assign src = shlReady ? shlIn : shiftReg;

	// Next shift would flip the sign
	assign ovf = src[31] ^ src[30];
	assign stepped = ovf ? (src[31] ? `MIN_32 : `MAX_32) : (src <<< 1);

	assign nextCnt = shlReady ? CNT_W'(`LSP_SHIFT - 1) : cnt - 1'b1;
	assign finish = ovf || (nextCnt == '0);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			shlDone <= 1'b0;
			cnt <= '0;
		end
		else
		begin
			shlDone <= 1'b0;
			if (shlReady || busy)
			begin
				shiftReg <= stepped;
				cnt <= nextCnt;
				busy <= !finish;
				shlDone <= finish;
			end
		end
	end

	// Holds the last value, saturated or not
	assign shlOut = shiftReg;

endmodule

`default_nettype wire

// ==== lspPrevExtract.sv ====
`default_nettype none

`include "g729_params.svh"

module lspPrevExtract import lspPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire start,
	input wire lspBases bases,
	output logic done,
	output memReq engReq,
	input wire word32 rdData,
	input wire engRdValid,
	output word16 a,
	output word16 b,
	output word32 acc,
	input wire word32 multOut,
	input wire word32 msuOut,
	output logic shlReady,
	output word32 shlIn,
	input wire shlDone,
	input wire word32 shlOut
);

	localparam int J_W = $clog2(`LPC_ORDER);
	localparam int K_W = $clog2(`MA_ORDER);

	engineState state;
	lspBases basesReg;
	logic [J_W-1:0] j;
	logic [K_W-1:0] k;
	word32 accReg;
	word16 freqReg;
	word16 fgReg;
	word16 invReg;
	memAddr jOff;
	memAddr matOff;

	// Element [k][j] sits at base + M*k + j
	assign jOff = memAddr'(j);
	assign matOff = memAddr'(k * `LPC_ORDER) + jOff;

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			j <= '0;
			k <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						basesReg <= bases;
						j <= '0;
						state <= READ_LSP;
					end
				end
				READ_LSP:
				begin
					// lsp[j] into the high half
					if (engRdValid)
					begin
						accReg <= {rdData[15:0], 16'h0000};
						k <= '0;
						state <= READ_FREQ;
					end
				end
				READ_FREQ:
				begin
					if (engRdValid)
					begin
						freqReg <= rdData[15:0];
						state <= READ_FG;
					end
				end
				READ_FG:
				begin
					if (engRdValid)
					begin
						fgReg <= rdData[15:0];
						state <= ACCUM;
					end
				end
				ACCUM:
				begin
					accReg <= msuOut;
					if (k == K_W'(`MA_ORDER - 1))
					begin
						state <= READ_INV;
					end
					else
					begin
						k <= k + 1'b1;
						state <= READ_FREQ;
					end
				end
				READ_INV:
				begin
					if (engRdValid)
					begin
						invReg <= rdData[15:0];
						state <= MULT;
					end
				end
				MULT:
				begin
					state <= SHIFT;
				end
				SHIFT:
				begin
					if (shlDone)
					begin
						state <= WRITE;
					end
				end
				WRITE:
				begin
					if (j == J_W'(`LPC_ORDER - 1))
					begin
						state <= FINISH;
					end
					else
					begin
						j <= j + 1'b1;
						state <= READ_LSP;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Memory requests
	//////////////////////////////////////////////////

	// A read is issued once, then the engine waits for engRdValid
	always_comb
	begin
		engReq = '0;
		case (state)
			READ_LSP:
			begin
				engReq.re = !engRdValid;
				engReq.addr = basesReg.lsp + jOff;
			end
			READ_FREQ:
			begin
				engReq.re = !engRdValid;
				engReq.addr = basesReg.freqPrev + matOff;
			end
			READ_FG:
			begin
				engReq.re = !engRdValid;
				engReq.addr = basesReg.fg + matOff;
			end
			READ_INV:
			begin
				engReq.re = !engRdValid;
				engReq.addr = basesReg.fgSumInv + jOff;
			end
			WRITE:
			begin
				engReq.we = 1'b1;
				engReq.addr = basesReg.lspEle + jOff;
				engReq.wrData = {{16{shlOut[31]}}, shlOut[31:16]};
			end
			default:
			begin
				engReq = '0;
			end
		endcase
	end

	// Arithmetic operands, high half times fg_sum_inv in MULT
	assign a = (state == MULT) ? accReg[31:16] : freqReg;
	assign b = (state == MULT) ? invReg : fgReg;
	assign acc = accReg;

	// Product goes straight into the shifter
	assign shlReady = (state == MULT);
	assign shlIn = multOut;

	assign done = (state == FINISH);

endmodule

`default_nettype wire

// ==== lspPrevExtractTop.sv ====
`default_nettype none

module lspPrevExtractTop import lspPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire start,
	input wire lspBases bases,
	output logic done,
	input wire memReq hostReq,
	output logic hostGnt,
	output word32 rdData,
	output logic hostRdValid
);

	memReq engReq;
	logic engRdValid;
	word16 a;
	word16 b;
	word32 acc;
	word32 multOut;
	word32 msuOut;
	logic shlReady;
	word32 shlIn;
	logic shlDone;
	word32 shlOut;
	memAddr memWrAddr;
	memAddr memRdAddr;
	word32 memWrData;
	logic memWe;

	//////////////////////////////////////////////////
	// Engine and arithmetic
	//////////////////////////////////////////////////
	lspPrevExtract i_engine (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bases(bases),
		.done(done),
		.engReq(engReq),
		.rdData(rdData),
		.engRdValid(engRdValid),
		.a(a),
		.b(b),
		.acc(acc),
		.multOut(multOut),
		.msuOut(msuOut),
		.shlReady(shlReady),
		.shlIn(shlIn),
		.shlDone(shlDone),
		.shlOut(shlOut)
	);

	mulSubUnit i_mulSub (
		.a(a),
		.b(b),
		.acc(acc),
		.multOut(multOut),
		.msuOut(msuOut)
	);

	lShiftSeq i_shl (
		.clk(clk),
		.rstN(rstN),
		.shlReady(shlReady),
		.shlIn(shlIn),
		.shlDone(shlDone),
		.shlOut(shlOut)
	);

	//////////////////////////////////////////////////
	// Shared scratch memory
	//////////////////////////////////////////////////
	memArbiter i_arb (
		.clk(clk),
		.rstN(rstN),
		.hostReq(hostReq),
		.engReq(engReq),
		.hostGnt(hostGnt),
		.hostRdValid(hostRdValid),
		.engRdValid(engRdValid),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.memRdAddr(memRdAddr)
	);

	scratchMemory i_mem (
		.clk(clk),
		.wrAddr(memWrAddr),
		.wrData(memWrData),
		.we(memWe),
		.rdAddr(memRdAddr),
		.rdData(rdData)
	);

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`default_nettype none

module tbClock
#(
	parameter int PERIOD = 10
)
(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Reset low for three rising edges, released on a falling edge
	initial
	begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== lspPrevExtractTb.sv ====
`default_nettype none

`include "g729_params.svh"

module lspPrevExtractTb import lspPkg::*;
();

	localparam int NUM_TESTS = 5;
	localparam int CLK_PERIOD = 10;
	// Worst cost of one coefficient, two loads, runs and readbacks in one test
	localparam int COEF_CYCLES = 128;
	localparam int MAT_SIZE = `LPC_ORDER * `MA_ORDER;
	localparam longint MAX32 = 64'sd2147483647;
	localparam longint MIN32 = -MAX32 - 1;

	logic clk;
	logic rstN;
	logic start;
	lspBases bases;
	logic done;
	memReq hostReq;
	logic hostGnt;
	word32 rdData;
	logic hostRdValid;

	// Host view of memory and the operands of the current load
	word32 shadow [`MEM_DEPTH];
	word16 curLsp [`LPC_ORDER];
	word16 curFreq [MAT_SIZE];
	word16 curFg [MAT_SIZE];
	word16 curInv [`LPC_ORDER];
	word32 expected [2][`LPC_ORDER];

	logic [31:0] lfsrState;
	int errCount;
	int checkCount;
	int lastErr;
	int doneCount;

	tbClock #(.PERIOD(CLK_PERIOD)) i_clock (
		.clk(clk),
		.rstN(rstN)
	);

	lspPrevExtractTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bases(bases),
		.done(done),
		.hostReq(hostReq),
		.hostGnt(hostGnt),
		.rdData(rdData),
		.hostRdValid(hostRdValid)
	);

	//////////////////////////////////////////////////
	// Random numbers and reference model
	//////////////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic fb;
		int i;
		val = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic word32 sext16(input word16 v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic longint clamp32(input longint v);
		if (v > MAX32)
		begin
			return MAX32;
		end
		if (v < MIN32)
		begin
			return MIN32;
		end
		return v;
	endfunction

	function automatic word32 refMult(input word16 x, input word16 y);
		return word32'(clamp32(2 * longint'(x) * longint'(y)));
	endfunction

	function automatic word32 refMsu(input word32 accIn, input word16 x, input word16 y);
		return word32'(clamp32(longint'(accIn) - longint'(refMult(x, y))));
	endfunction

	// Stops at the first doubling that leaves the 32-bit range
	function automatic word32 refShl(input word32 x, input int n);
		longint v;
		int i;
		v = longint'(x);
		for (i = 0; i < n; i++)
		begin
			v = v * 2;
			if (v != clamp32(v))
			begin
				return word32'(clamp32(v));
			end
		end
		return word32'(v);
	endfunction

	function automatic word32 refLspEle(input int j);
		word32 r;
		word16 hi;
		int k;
		r = {curLsp[j], 16'h0000};
		for (k = 0; k < `MA_ORDER; k++)
		begin
			r = refMsu(r, curFreq[k * `LPC_ORDER + j], curFg[k * `LPC_ORDER + j]);
		end
		hi = r[31:16];
		r = refShl(refMult(hi, curInv[j]), `LSP_SHIFT);
		return sext16(r[31:16]);
	endfunction

	function automatic word16 pickValue(input logic corner);
		if (corner)
		begin
			return randBits(1) ? 16'sh7fff : 16'sh8000;
		end
		return word16'(randBits(16));
	endfunction

	function automatic lspBases makeBases(input memAddr origin);
		lspBases bs;
		bs.lsp = origin;
		bs.freqPrev = origin + 11'd16;
		bs.fg = origin + 11'd64;
		bs.fgSumInv = origin + 11'd112;
		bs.lspEle = origin + 11'd128;
		return bs;
	endfunction

	//////////////////////////////////////////////////
	// Checks and host access
	//////////////////////////////////////////////////
	task automatic checkValue(input string name, input word32 exp, input word32 act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic testDone(input int num, input string name);
		$display("test %0d %s: %0d mismatches", num, name, errCount - lastErr);
		lastErr = errCount;
	endtask

	// Grant is sampled just after the falling edge, once inputs have settled
	task automatic waitGrant();
		#1;
		while (hostGnt !== 1'b1)
		begin
			@(negedge clk);
			#1;
		end
	endtask

	task automatic hostWrite(input memAddr addr, input word32 data);
		@(negedge clk);
		hostReq.addr = addr;
		hostReq.wrData = data;
		hostReq.we = 1'b1;
		hostReq.re = 1'b0;
		waitGrant();
		@(negedge clk);
		hostReq = '0;
		shadow[addr] = data;
	endtask

	task automatic hostRead(input memAddr addr, output word32 data);
		int tries;
		@(negedge clk);
		hostReq.addr = addr;
		hostReq.wrData = '0;
		hostReq.we = 1'b0;
		hostReq.re = 1'b1;
		waitGrant();
		@(negedge clk);
		hostReq = '0;
		tries = 0;
		while (hostRdValid !== 1'b1 && tries < 4)
		begin
			@(negedge clk);
			tries++;
		end
		if (hostRdValid !== 1'b1)
		begin
			errCount++;
			$display("Host read of address %0d never returned its data", addr);
		end
		data = rdData;
	endtask

	//////////////////////////////////////////////////
	// Engine runs
	//////////////////////////////////////////////////
	task automatic loadSet(input lspBases bs, input logic corner, input int slot);
		int i;
		for (i = 0; i < `LPC_ORDER; i++)
		begin
			curLsp[i] = pickValue(corner);
			hostWrite(memAddr'(bs.lsp + i), sext16(curLsp[i]));
		end
		for (i = 0; i < MAT_SIZE; i++)
		begin
			curFreq[i] = pickValue(corner);
			hostWrite(memAddr'(bs.freqPrev + i), sext16(curFreq[i]));
			curFg[i] = pickValue(corner);
			hostWrite(memAddr'(bs.fg + i), sext16(curFg[i]));
		end
		for (i = 0; i < `LPC_ORDER; i++)
		begin
			curInv[i] = pickValue(corner);
			hostWrite(memAddr'(bs.fgSumInv + i), sext16(curInv[i]));
			expected[slot][i] = refLspEle(i);
		end
	endtask

	task automatic startRun(input lspBases bs);
		@(negedge clk);
		bases = bs;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < `LPC_ORDER * COEF_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			errCount++;
			$display("Engine did not signal done within %0d cycles", cycles);
		end
	endtask

	task automatic checkResults(input lspBases bs, input int slot);
		word32 v;
		int j;
		for (j = 0; j < `LPC_ORDER; j++)
		begin
			hostRead(memAddr'(bs.lspEle + j), v);
			checkValue($sformatf("lspEle[%0d]", j), expected[slot][j], v);
		end
	endtask

	always @(negedge clk)
	begin
		if (done === 1'b1)
		begin
			doneCount++;
		end
	end

	// Watchdog sized from test count and per-coefficient cost
	initial
	begin
		#(NUM_TESTS * 10 * COEF_CYCLES * 4 * CLK_PERIOD);
		$display("Run timed out before all tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	initial
	begin
		word32 v;
		memAddr addrs [24];
		lspBases bsA;
		lspBases bsB;
		int d0;
		int i;
		lfsrState = 32'h701b_3cbb;
		errCount = 0;
		checkCount = 0;
		lastErr = 0;
		doneCount = 0;
		start = 1'b0;
		bases = '0;
		hostReq = '0;
		wait (rstN === 1'b1);
		@(negedge clk);
		checkValue("done", 0, done);
		checkValue("hostGnt", 0, hostGnt);
		checkValue("hostRdValid", 0, hostRdValid);

		for (i = 0; i < 24; i++)
		begin
			addrs[i] = memAddr'(randBits(`MEM_ADDR_W));
			hostWrite(addrs[i], randBits(32));
		end
		for (i = 0; i < 24; i++)
		begin
			hostRead(addrs[i], v);
			checkValue($sformatf("rdData@%0d", addrs[i]), shadow[addrs[i]], v);
		end
		testDone(1, "host write and readback");

		bsA = makeBases(11'd0);
		loadSet(bsA, 1'b0, 0);
		startRun(bsA);
		waitDone();
		checkResults(bsA, 0);
		testDone(2, "single extraction");

		bsA = makeBases(11'd256);
		loadSet(bsA, 1'b1, 0);
		startRun(bsA);
		waitDone();
		checkResults(bsA, 0);
		testDone(3, "saturation corners");

		// Unrelated array read by the host while the engine runs
		bsA = makeBases(11'd512);
		loadSet(bsA, 1'b0, 0);
		for (i = 0; i < 16; i++)
		begin
			hostWrite(memAddr'(1536 + i), randBits(32));
		end
		startRun(bsA);
		fork
			waitDone();
			begin
				for (i = 0; i < 16; i++)
				begin
					hostRead(memAddr'(1536 + i), v);
					checkValue($sformatf("rdData@%0d", 1536 + i), shadow[1536 + i], v);
				end
			end
		join
		checkResults(bsA, 0);
		testDone(4, "host access during a run");

		bsA = makeBases(11'd768);
		bsB = makeBases(11'd1024);
		loadSet(bsA, 1'b0, 0);
		loadSet(bsB, 1'b0, 1);
		d0 = doneCount;
		// Each busy start carries the other run's bases and must be ignored
		startRun(bsA);
		repeat (6) @(negedge clk);
		startRun(bsB);
		waitDone();
		startRun(bsB);
		repeat (6) @(negedge clk);
		startRun(bsA);
		waitDone();
		@(negedge clk);
		checkValue("done pulses", 2, doneCount - d0);
		checkResults(bsA, 0);
		checkResults(bsB, 1);
		testDone(5, "back-to-back runs");

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errCount);
		if (errCount == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
lspPkg.sv
scratchMemory.sv
memArbiter.sv
mulSubUnit.sv
lShiftSeq.sv
lspPrevExtract.sv
lspPrevExtractTop.sv
tbClock.sv
lspPrevExtractTb.sv

// ==== Bender.yml ====
package:
  name: lsp_prev_extract

sources:
  - include_dirs:
      - .
    files:
      - lspPkg.sv
      - scratchMemory.sv
      - memArbiter.sv
      - mulSubUnit.sv
      - lShiftSeq.sv
      - lspPrevExtract.sv
      - lspPrevExtractTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - lspPrevExtractTb.sv
